/* compile.f */
rtl/cpuTypesPkg.sv
rtl/cacheTypesPkg.sv
rtl/dcache.sv
rtl/snoopArbiter.sv
rtl/memoryController.sv
rtl/coherentMemSys.sv
verif/coherenceChecker.sv
verif/tbCoherentMemSys.sv

/* run.sh */
#!/bin/sh
# build the testbench and RTL with Verilator, then run the simulation
# the exit status is nonzero when the build or the run fails
cd "$(dirname "$0")" &&
  verilator --binary --assert -j 0 --top-module tbCoherentMemSys \
    -f compile.f -o simv &&
  ./obj_dir/simv ||
  { echo "build or simulation failed"; exit 1; }

/* verif/tbCoherentMemSys.sv */
// testbench with directed and random traffic, credit tracking and a reference memory model
`timescale 1ns/1ps
`default_nettype none

module tbCoherentMemSys;
  import cpuTypesPkg::*;
  import cacheTypesPkg::*;

  localparam int RANDOM_OPS  = 2000;
  localparam int WAIT_LIMIT  = 2000;
  localparam int IDLE_CYCLES = 20;

  logic                      CLK;
  logic                      nRST;
  coreReq_t  [NUM_CORES-1:0] coreReq;
  coreResp_t [NUM_CORES-1:0] coreResp;

  // reference memory and per-core bookkeeping
  word_t       model [MEM_WORDS];
  coreReq_t    pending [NUM_CORES][$];
  coreReq_t    staged [NUM_CORES];
  int          credits [NUM_CORES];
  logic [31:0] rngState;

  coherentMemSys i_dut (
    .CLK      (CLK),
    .nRST     (nRST),
    .coreReq  (coreReq),
    .coreResp (coreResp)
  );

  always #20 CLK = ~CLK;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t blockAddr(input logic [25:0] tag, input logic [2:0] index,
                                      input logic blkOff);
    memAddr_u a;
    a          = '0;
    a.f.tag    = tag;
    a.f.index  = index;
    a.f.blkOff = blkOff;
    return a.raw;
  endfunction

  // 4 tags over the even sets, so lines conflict within and across caches
  function automatic word_t poolAddr(input logic [4:0] k);
    return blockAddr(26'(k[4:3]), {k[2:1], 1'b0}, k[0]);
  endfunction

  function automatic logic [MEM_ADDR_BITS-1:0] wordIndex(input word_t addr);
    return addr[2 +: MEM_ADDR_BITS];
  endfunction

  function automatic logic creditsRestored();
    logic idle;
    idle = 1'b1;
    for (int c = 0; c < NUM_CORES; c++) begin
      if (credits[c] != REQ_CREDITS || pending[c].size() != 0)
        idle = 1'b0;
    end
    return idle;
  endfunction

  task automatic reportError(input string msg);
    $display("ERROR at %0d ns: %s", $time, msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping after a failure");
  endtask

  task automatic stage(input int core, input logic write, input word_t addr, input word_t data);
    staged[core]          = '0;
    staged[core].valid    = 1'b1;
    staged[core].write    = write;
    staged[core].addr.raw = addr;
    staged[core].wdata    = data;
  endtask

  // responses are in request order per core, stores update the model on response
  task automatic collectResponses();
    coreReq_t req;
    word_t    expected;
    for (int c = 0; c < NUM_CORES; c++) begin
      if (coreResp[c].valid) begin
        assert (pending[c].size() != 0)
          else reportError($sformatf("core %0d responded with no request outstanding", c));
        req = pending[c].pop_front();
        credits[c]++;
        if (req.write) begin
          model[wordIndex(req.addr.raw)] = req.wdata;
        end else begin
          expected = model[wordIndex(req.addr.raw)];
          assert (coreResp[c].rdata == expected)
            else reportError($sformatf("core %0d load %08h returned %08h, expected %08h",
                                       c, req.addr.raw, coreResp[c].rdata, expected));
        end
      end
    end
  endtask

  // drive after the edge, sample at the falling edge
  task automatic runCycle();
    @(posedge CLK);
    #1;
    for (int c = 0; c < NUM_CORES; c++) begin
      coreReq[c] = staged[c];
      if (staged[c].valid) begin
        pending[c].push_back(staged[c]);
        credits[c]--;
      end
      staged[c] = '0;
    end
    @(negedge CLK);
    collectResponses();
  endtask

  task automatic issue(input int core, input logic write, input word_t addr, input word_t data);
    int n;
    n = 0;
    while (credits[core] == 0) begin
      runCycle();
      n++;
      if (n > WAIT_LIMIT) begin
        abortRun($sformatf("timeout: core %0d got no credit back within %0d cycles",
                           core, WAIT_LIMIT));
      end
    end
    stage(core, write, addr, data);
    runCycle();
  endtask

  task automatic drainAll();
    int n;
    n = 0;
    while (!creditsRestored()) begin
      runCycle();
      n++;
      if (n > WAIT_LIMIT) begin
        abortRun($sformatf("timeout: outstanding requests not answered within %0d cycles",
                           WAIT_LIMIT));
      end
    end
  endtask

  initial begin
    int         issued;
    int         stall;
    logic       progress;
    word_t      addrA;
    CLK      = 1'b0;
    nRST     = 1'b0;
    coreReq  = '0;
    rngState = 32'h6a00_55ac;
    foreach (model[i])
      model[i] = '0;
    for (int c = 0; c < NUM_CORES; c++) begin
      staged[c]  = '0;
      credits[c] = REQ_CREDITS;
    end
    repeat (16) @(posedge CLK);
    #1;
    nRST = 1'b1;

    // quiet after reset, any response here has no request behind it
    repeat (IDLE_CYCLES)
      runCycle();

    // single core store then load, and a never written word
    addrA    = blockAddr(26'd4, 3'd0, 1'b0);
    rngState = xorshift(rngState);
    issue(0, 1'b1, addrA, rngState);
    issue(0, 1'b0, addrA, '0);
    drainAll();
    issue(0, 1'b0, blockAddr(26'd15, 3'd7, 1'b1), '0);
    drainAll();

    // M to S on the remote read, then upgrade with invalidate, then M back to S
    addrA    = blockAddr(26'd6, 3'd1, 1'b1);
    rngState = xorshift(rngState);
    issue(0, 1'b1, addrA, rngState);
    drainAll();
    issue(1, 1'b0, addrA, '0);
    drainAll();
    rngState = xorshift(rngState);
    issue(1, 1'b1, addrA, rngState);
    drainAll();
    issue(0, 1'b0, addrA, '0);
    drainAll();

    // three tags in one 2-way set force a dirty eviction
    for (int t = 0; t < 3; t++) begin
      rngState = xorshift(rngState);
      issue(1, 1'b1, blockAddr(26'(8 + t), 3'd5, 1'b0), rngState);
    end
    drainAll();
    for (int t = 0; t < 3; t++)
      issue(1, 1'b0, blockAddr(26'(8 + t), 3'd5, 1'b0), '0);
    drainAll();

    // random mixed traffic on both cores
    issued = 0;
    stall  = 0;
    while (issued < RANDOM_OPS) begin
      progress = 1'b0;
      for (int c = 0; c < NUM_CORES; c++) begin
        rngState = xorshift(rngState);
        if (issued < RANDOM_OPS && credits[c] > 0 && rngState[7:6] != 2'b00) begin
          addrA    = poolAddr(rngState[5:1]);
          progress = rngState[0];
          rngState = xorshift(rngState);
          stage(c, progress, addrA, rngState);
          issued++;
          progress = 1'b1;
        end
      end
      runCycle();
      if (progress)
        stall = 0;
      else
        stall++;
      if (stall > WAIT_LIMIT) begin
        abortRun($sformatf("timeout: random traffic stalled for %0d cycles", WAIT_LIMIT));
      end
    end
    drainAll();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/coherenceChecker.sv */
// concurrent assertions on bus grant, bus ownership, MSI exclusivity and queue depth
`timescale 1ns/1ps
`default_nettype none

module coherenceChecker (
  input logic                                                         CLK,
  input logic                                                         nRST,
  input logic [cpuTypesPkg::NUM_CORES-1:0]                            busGrant,
  input logic [cpuTypesPkg::NUM_CORES-1:0]                            busDone,
  input logic [cpuTypesPkg::NUM_CORES-1:0]                            busOwner,
  input logic [cpuTypesPkg::NUM_CORES-1:0][cpuTypesPkg::REQ_PTR_BITS:0] qCount,
  input cacheTypesPkg::cacheLine_t [cpuTypesPkg::NUM_CORES-1:0]
                                   [cacheTypesPkg::NUM_SETS-1:0]
                                   [cacheTypesPkg::NUM_WAYS-1:0]      lines
);
  import cpuTypesPkg::*;
  import cacheTypesPkg::*;

  logic mTwice;

  // same tag valid and dirty in two caches
  always_comb begin
    mTwice = 1'b0;
    for (int a = 0; a < NUM_CORES; a++) begin
      for (int b = a + 1; b < NUM_CORES; b++) begin
        for (int s = 0; s < NUM_SETS; s++) begin
          for (int x = 0; x < NUM_WAYS; x++) begin
            for (int y = 0; y < NUM_WAYS; y++) begin
              if (lines[a][s][x].valid && lines[a][s][x].dirty &&
                  lines[b][s][y].valid && lines[b][s][y].dirty &&
                  lines[a][s][x].tag == lines[b][s][y].tag)
                mTwice = 1'b1;
            end
          end
        end
      end
    end
  end

  assert property (@(posedge CLK) disable iff (!nRST) $onehot0(busGrant))
    else $error("bus grant is neither zero nor one-hot");
  assert property (@(posedge CLK) disable iff (!nRST) $onehot0(busOwner))
    else $error("bus owner is neither zero nor one-hot");
  assert property (@(posedge CLK) disable iff (!nRST) !mTwice)
    else $error("a line is modified in two caches at once");

  for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
    assert property (@(posedge CLK) disable iff (!nRST)
                     busGrant[i] && !busDone[i] |=> busGrant[i])
      else $error("grant to cache %0d dropped before its bus done", i);
    assert property (@(posedge CLK) disable iff (!nRST)
                     qCount[i] <= (REQ_PTR_BITS+1)'(REQ_CREDITS))
      else $error("request queue of cache %0d overflowed", i);
  end

endmodule

// arbiter outputs and per-cache state seen from the top level
bind coherentMemSys coherenceChecker i_checker (
  .CLK      (CLK),
  .nRST     (nRST),
  .busGrant (i_arbiter.busGrant),
  .busDone  (busDone),
  .busOwner (i_arbiter.busOwner),
  .qCount   ({g_cache[1].i_dcache.qCount, g_cache[0].i_dcache.qCount}),
  .lines    ({g_cache[1].i_dcache.lines, g_cache[0].i_dcache.lines})
);

`default_nettype wire

/* rtl/coherentMemSys.sv */
// top level with per-core data caches, snoop arbiter and memory controller
`timescale 1ns/1ps
`default_nettype none

module coherentMemSys (
  input  logic                                                 CLK,
  input  logic                                                 nRST,
  input  cpuTypesPkg::coreReq_t  [cpuTypesPkg::NUM_CORES-1:0]  coreReq,
  output cpuTypesPkg::coreResp_t [cpuTypesPkg::NUM_CORES-1:0]  coreResp
);
  import cpuTypesPkg::*;
  import cacheTypesPkg::*;

  busReq_t  [NUM_CORES-1:0] busReq;
  memReq_t  [NUM_CORES-1:0] memReq;
  memResp_t [NUM_CORES-1:0] memResp;
  snoop_t                   snoop;
  logic     [NUM_CORES-1:0] busGrant, busDone, snoopHitM, wbDone, busOwner;

  snoopArbiter i_arbiter (
    .CLK       (CLK),
    .nRST      (nRST),
    .busReq    (busReq),
    .busGrant  (busGrant),
    .busDone   (busDone),
    .snoop     (snoop),
    .snoopHitM (snoopHitM),
    .wbDone    (wbDone),
    .busOwner  (busOwner)
  );

  memoryController i_memCtrl (
    .CLK      (CLK),
    .nRST     (nRST),
    .busOwner (busOwner),
    .memReq   (memReq),
    .memResp  (memResp)
  );

  for (genvar i = 0; i < NUM_CORES; i++) begin : g_cache
    dcache i_dcache (
      .CLK       (CLK),
      .nRST      (nRST),
      .coreReq   (coreReq[i]),
      .coreResp  (coreResp[i]),
      .busReq    (busReq[i]),
      .busGrant  (busGrant[i]),
      .busDone   (busDone[i]),
      .snoop     (snoop),
      .snoopHitM (snoopHitM[i]),
      .isOwner   (busOwner[i]),
      .wbDone    (wbDone[i]),
      .memReq    (memReq[i]),
      .memResp   (memResp[i])
    );
  end

endmodule

`default_nettype wire

/* rtl/memoryController.sv */
// word-addressed main memory with fixed latency, serving the current bus owner
`timescale 1ns/1ps
`default_nettype none

module memoryController (
  input  logic                                                 CLK,
  input  logic                                                 nRST,
  input  logic [cpuTypesPkg::NUM_CORES-1:0]                    busOwner,
  input  cacheTypesPkg::memReq_t  [cpuTypesPkg::NUM_CORES-1:0] memReq,
  output cacheTypesPkg::memResp_t [cpuTypesPkg::NUM_CORES-1:0] memResp
);
  import cpuTypesPkg::*;
  import cacheTypesPkg::*;

  word_t                    mem [MEM_WORDS];
  memReq_t                  sel;
  logic [LAT_BITS-1:0]      cnt;
  logic [NUM_CORES-1:0]     readyVec;
  logic [MEM_ADDR_BITS-1:0] wordAddr;
  word_t                    rdata;

  // owner is one-hot or zero
  always_comb begin
    sel = '0;
    for (int k = 0; k < NUM_CORES; k++) begin
      if (busOwner[k])
        sel = memReq[k];
    end
  end

  assign wordAddr = sel.addr[2 +: MEM_ADDR_BITS];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cnt      <= '0;
      readyVec <= '0;
      rdata    <= '0;
      mem      <= '{default: '0};
    end else begin
      readyVec <= '0;
      // the ready cycle itself does not start a new access
      if (sel.valid && readyVec == '0) begin
        if (cnt == LAT_BITS'(MEM_LATENCY - 1)) begin
          cnt      <= '0;
          readyVec <= busOwner;
          if (sel.write)
            mem[wordAddr] <= sel.wdata;
          else
            rdata <= mem[wordAddr];
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int k = 0; k < NUM_CORES; k++) begin
      memResp[k].ready = readyVec[k];
      memResp[k].rdata = rdata;
    end
  end

endmodule

`default_nettype wire

/* rtl/snoopArbiter.sv */
// round-robin bus grant, snoop broadcast and bus ownership sequencing
`timescale 1ns/1ps
`default_nettype none

module snoopArbiter (
  input  logic                                                CLK,
  input  logic                                                nRST,
  input  cacheTypesPkg::busReq_t [cpuTypesPkg::NUM_CORES-1:0] busReq,
  output logic [cpuTypesPkg::NUM_CORES-1:0]                   busGrant,
  input  logic [cpuTypesPkg::NUM_CORES-1:0]                   busDone,
  output cacheTypesPkg::snoop_t                               snoop,
  input  logic [cpuTypesPkg::NUM_CORES-1:0]                   snoopHitM,
  input  logic [cpuTypesPkg::NUM_CORES-1:0]                   wbDone,
  output logic [cpuTypesPkg::NUM_CORES-1:0]                   busOwner
);
  import cpuTypesPkg::*;
  import cacheTypesPkg::*;

  typedef enum logic [2:0] {IDLE, GRANT, SNOOP, SNOOPWAIT, SNOOPWB, FILL} arbState_t;

  arbState_t            state;
  logic [CORE_BITS-1:0] rrPtr, pick, cur;
  logic                 anyReq;
  logic [LINE_BITS-1:0] curLine;
  logic                 curExcl;
  logic [NUM_CORES-1:0] curOneHot, hitM;

  // first pending request at or after the pointer
  always_comb begin
    int cand;
    anyReq = 1'b0;
    pick   = rrPtr;
    for (int k = NUM_CORES - 1; k >= 0; k--) begin
      cand = (int'(rrPtr) + k) % NUM_CORES;
      if (busReq[cand].valid) begin
        anyReq = 1'b1;
        pick   = CORE_BITS'(cand);
      end
    end
  end

  assign curOneHot = NUM_CORES'(1) << cur;
  // the requester never answers its own snoop
  assign hitM      = snoopHitM & ~curOneHot;

  assign snoop.valid      = (state == SNOOP);
  assign snoop.invalidate = curExcl;
  assign snoop.lineAddr   = curLine;
  assign snoop.requester  = cur;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state    <= IDLE;
      busGrant <= '0;
      busOwner <= '0;
      rrPtr    <= '0;
      cur      <= '0;
      curLine  <= '0;
      curExcl  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (anyReq) begin
            cur      <= pick;
            curLine  <= busReq[pick].lineAddr;
            curExcl  <= busReq[pick].exclusive;
            busGrant <= NUM_CORES'(1) << pick;
            busOwner <= NUM_CORES'(1) << pick;
            state    <= GRANT;
          end
        end
        // requester writes back its victim
        GRANT: begin
          if (wbDone[cur]) begin
            busOwner <= '0;
            state    <= SNOOP;
          end
        end
        SNOOP: state <= SNOOPWAIT;
        SNOOPWAIT: begin
          if (|hitM) begin
            busOwner <= hitM;
            state    <= SNOOPWB;
          end else begin
            busOwner <= curOneHot;
            state    <= FILL;
          end
        end
        SNOOPWB: begin
          if (|(wbDone & busOwner)) begin
            busOwner <= curOneHot;
            state    <= FILL;
          end
        end
        FILL: begin
          if (busDone[cur]) begin
            busGrant <= '0;
            busOwner <= '0;
            rrPtr    <= CORE_BITS'((int'(cur) + 1) % NUM_CORES);
            state    <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/dcache.sv */
// coherent 2-way write-back data cache with credited request queue and snoop control
`timescale 1ns/1ps
`default_nettype none

module dcache (
  input  logic                     CLK,
  input  logic                     nRST,
  input  cpuTypesPkg::coreReq_t    coreReq,
  output cpuTypesPkg::coreResp_t   coreResp,
  output cacheTypesPkg::busReq_t   busReq,
  input  logic                     busGrant,
  output logic                     busDone,
  input  cacheTypesPkg::snoop_t    snoop,
  output logic                     snoopHitM,
  input  logic                     isOwner,
  output logic                     wbDone,
  output cacheTypesPkg::memReq_t   memReq,
  input  cacheTypesPkg::memResp_t  memResp
);
  import cpuTypesPkg::*;
  import cacheTypesPkg::*;

  typedef enum logic [2:0] {LOOKUP, BUSREQ, VICTIM, FILL, DONE} ctrl_t;

  // request queue
  coreReq_t                queue [REQ_CREDITS];
  logic [REQ_PTR_BITS-1:0] wrPtr, rdPtr;
  logic [REQ_PTR_BITS:0]   qCount;
  coreReq_t                head;
  logic                    deq;

  // line storage, lru bit names the way to evict next
  cacheLine_t [NUM_SETS-1:0][NUM_WAYS-1:0] lines;
  logic [NUM_SETS-1:0]                     lru;

  // miss control
  ctrl_t               state;
  logic                mWay, mUpg, mWord;
  logic [IDX_BITS-1:0] idx;
  logic [NUM_WAYS-1:0] hitVec;
  logic                hit, hitWay, hitOk, victWay;
  logic                victWb, victLast, fillLast;
  cacheLine_t          hitLine, mLine;
  msi_t                hitState;

  // snoop side
  logic [IDX_BITS-1:0] sIdx, snpIdx;
  logic [TAG_BITS-1:0] sTag;
  logic [NUM_WAYS-1:0] sHitVec;
  logic                sWay, snpActive;
  msi_t                sState;
  logic                snpPend, snpInv, snpWay, snpWord, snpLast;
  cacheLine_t          snpLine;
  memAddr_u            vAddr, fAddr, sAddr;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wrPtr  <= '0;
      rdPtr  <= '0;
      qCount <= '0;
    end else begin
      if (coreReq.valid)
        wrPtr <= wrPtr + 1'b1;
      if (deq)
        rdPtr <= rdPtr + 1'b1;
      qCount <= qCount + (REQ_PTR_BITS+1)'(coreReq.valid) - (REQ_PTR_BITS+1)'(deq);
    end
  end

  always_ff @(posedge CLK) begin
    if (coreReq.valid)
      queue[wrPtr] <= coreReq;
  end

  assign head = queue[rdPtr];

  // lookup of the queue head
  assign idx = head.addr.f.index;
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      hitVec[w]  = lines[idx][w].valid && (lines[idx][w].tag == head.addr.f.tag);
      sHitVec[w] = lines[sIdx][w].valid && (lines[sIdx][w].tag == sTag);
    end
  end

  assign hit      = |hitVec;
  assign hitWay   = hitVec[1];
  assign hitLine  = lines[idx][hitWay];
  assign hitState = msi_t'({hitLine.valid, hitLine.dirty});
  // a store needs the line in M
  assign hitOk    = hit && (!head.write || hitState == M);
  assign victWay  = !lines[idx][0].valid ? 1'b0 :
                    !lines[idx][1].valid ? 1'b1 : lru[idx];
  assign deq      = (state == LOOKUP) && (qCount != '0) && !snpPend && hitOk;
  assign mLine    = lines[idx][mWay];

  assign victWb   = (state == VICTIM) && !mUpg && mLine.valid && mLine.dirty;
  assign victLast = (state == VICTIM) && (!victWb || (memResp.ready && mWord));
  assign fillLast = (state == FILL) && isOwner && (mUpg || (memResp.ready && mWord));

  // snoop decode
  assign sIdx      = snoop.lineAddr[IDX_BITS-1:0];
  assign sTag      = snoop.lineAddr[LINE_BITS-1:IDX_BITS];
  assign sWay      = sHitVec[1];
  assign sState    = (|sHitVec) ? msi_t'({lines[sIdx][sWay].valid, lines[sIdx][sWay].dirty}) : I;
  // the granted cache is the requester and ignores its own snoop
  assign snpActive = snoop.valid && !busGrant;
  assign snpLine   = lines[snpIdx][snpWay];
  assign snpLast   = snpPend && isOwner && memResp.ready && snpWord;

  // word addresses for writeback and fill
  always_comb begin
    vAddr           = '0;
    vAddr.f.tag     = mLine.tag;
    vAddr.f.index   = idx;
    vAddr.f.blkOff  = mWord;
    fAddr           = head.addr;
    fAddr.f.blkOff  = mWord;
    fAddr.f.byteOff = '0;
    sAddr           = '0;
    sAddr.f.tag     = snpLine.tag;
    sAddr.f.index   = snpIdx;
    sAddr.f.blkOff  = snpWord;
  end

  always_comb begin
    memReq = '0;
    if (victWb) begin
      memReq.valid = 1'b1;
      memReq.write = 1'b1;
      memReq.addr  = vAddr.raw;
      memReq.wdata = mLine.data[mWord];
    end else if (state == FILL && isOwner && !mUpg) begin
      memReq.valid = 1'b1;
      memReq.addr  = fAddr.raw;
    end else if (snpPend && isOwner) begin
      memReq.valid = 1'b1;
      memReq.write = 1'b1;
      memReq.addr  = sAddr.raw;
      memReq.wdata = snpLine.data[snpWord];
    end
  end

  assign busReq.valid     = (state == BUSREQ);
  assign busReq.exclusive = head.write;
  assign busReq.lineAddr  = {head.addr.f.tag, head.addr.f.index};
  assign busDone          = (state == DONE);
  assign wbDone           = victLast | snpLast;

  // miss sequencing
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= LOOKUP;
      mWay  <= 1'b0;
      mUpg  <= 1'b0;
      mWord <= 1'b0;
    end else begin
      case (state)
        LOOKUP: begin
          if (qCount != '0 && !snpPend && !hitOk)
            state <= BUSREQ;
        end
        BUSREQ: begin
          // snoops may have changed the set while waiting, so decide here
          if (busGrant) begin
            mUpg  <= hit;
            mWay  <= hit ? hitWay : victWay;
            mWord <= 1'b0;
            state <= VICTIM;
          end
        end
        VICTIM: begin
          if (memResp.ready)
            mWord <= ~mWord;
          if (victLast)
            state <= FILL;
        end
        FILL: begin
          if (memResp.ready)
            mWord <= ~mWord;
          if (fillLast)
            state <= DONE;
        end
        default: state <= LOOKUP;
      endcase
    end
  end

  // line array, lru, response and snoop state
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      lines     <= '0;
      lru       <= '0;
      coreResp  <= '0;
      snoopHitM <= 1'b0;
      snpPend   <= 1'b0;
      snpInv    <= 1'b0;
      snpWay    <= 1'b0;
      snpWord   <= 1'b0;
      snpIdx    <= '0;
    end else begin
      coreResp.valid <= deq;
      if (deq) begin
        coreResp.rdata <= hitLine.data[head.addr.f.blkOff];
        lru[idx]       <= ~hitWay;
        if (head.write) begin
          lines[idx][hitWay].data[head.addr.f.blkOff] <= head.wdata;
          lines[idx][hitWay].dirty                    <= 1'b1;
        end
      end
      if (victLast && !mUpg)
        lines[idx][mWay].valid <= 1'b0;
      if (state == FILL && memResp.ready && !mUpg) begin
        lines[idx][mWay].tag         <= head.addr.f.tag;
        lines[idx][mWay].data[mWord] <= memResp.rdata;
      end
      // loads fill to S, stores end in M
      if (fillLast) begin
        lines[idx][mWay].valid <= 1'b1;
        lines[idx][mWay].dirty <= head.write;
        lru[idx]               <= ~mWay;
      end

      snoopHitM <= snpActive && (sState == M);
      if (snpActive && sState == M) begin
        snpPend <= 1'b1;
        snpIdx  <= sIdx;
        snpWay  <= sWay;
        snpInv  <= snoop.invalidate;
        snpWord <= 1'b0;
      end else if (snpActive && sState == S && snoop.invalidate) begin
        lines[sIdx][sWay].valid <= 1'b0;
      end
      if (snpPend && isOwner && memResp.ready)
        snpWord <= ~snpWord;
      // M drops to S on BusRd, to I on BusRdX
      if (snpLast) begin
        snpPend                     <= 1'b0;
        lines[snpIdx][snpWay].dirty <= 1'b0;
        if (snpInv)
          lines[snpIdx][snpWay].valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/cacheTypesPkg.sv */
// cache geometry, MSI state, line, bus, snoop and memory structs, memory constants
`default_nettype none

package cacheTypesPkg;

  localparam int NUM_SETS    = 8;
  localparam int NUM_WAYS    = 2;
  localparam int BLOCK_WORDS = 2;
  localparam int IDX_BITS    = $clog2(NUM_SETS);
  localparam int TAG_BITS    = 32 - IDX_BITS - $clog2(BLOCK_WORDS) - 2;
  localparam int LINE_BITS   = TAG_BITS + IDX_BITS;
  localparam int CORE_BITS   = (cpuTypesPkg::NUM_CORES > 1) ? $clog2(cpuTypesPkg::NUM_CORES) : 1;

  localparam int MEM_WORDS     = 256;
  localparam int MEM_LATENCY   = 2;
  localparam int MEM_ADDR_BITS = $clog2(MEM_WORDS);
  localparam int LAT_BITS      = $clog2(MEM_LATENCY + 1);

  // encoded as {valid, dirty}
  typedef enum logic [1:0] {
    I = 2'b00,
    S = 2'b10,
    M = 2'b11
  } msi_t;

  typedef struct packed {
    logic                                      valid;
    logic                                      dirty;
    logic [TAG_BITS-1:0]                       tag;
    cpuTypesPkg::word_t [BLOCK_WORDS-1:0]      data;
  } cacheLine_t;

  // exclusive set means BusRdX
  typedef struct packed {
    logic                 valid;
    logic                 exclusive;
    logic [LINE_BITS-1:0] lineAddr;
  } busReq_t;

  typedef struct packed {
    logic                 valid;
    logic                 invalidate;
    logic [LINE_BITS-1:0] lineAddr;
    logic [CORE_BITS-1:0] requester;
  } snoop_t;

  typedef struct packed {
    logic               valid;
    logic               write;
    cpuTypesPkg::word_t addr;
    cpuTypesPkg::word_t wdata;
  } memReq_t;

  typedef struct packed {
    logic               ready;
    cpuTypesPkg::word_t rdata;
  } memResp_t;

endpackage

`default_nettype wire

/* rtl/cpuTypesPkg.sv */
// core-side types: data word, address union, request and response structs, credit constants
`default_nettype none

package cpuTypesPkg;

  typedef logic [31:0] word_t;

  localparam int NUM_CORES    = 2;
  localparam int REQ_CREDITS  = 2;
  localparam int REQ_PTR_BITS = $clog2(REQ_CREDITS);

  // tag/index/offset view of a byte address
  typedef struct packed {
    logic [25:0] tag;
    logic [2:0]  index;
    logic        blkOff;
    logic [1:0]  byteOff;
  } addrFields_t;

  typedef union packed {
    word_t       raw;
    addrFields_t f;
  } memAddr_u;

  typedef struct packed {
    logic     valid;
    logic     write;
    memAddr_u addr;
    word_t    wdata;
  } coreReq_t;

  typedef struct packed {
    logic  valid;
    word_t rdata;
  } coreResp_t;

endpackage

`default_nettype wire
